//--- hdl/mcu_pkg.sv
/*
 * mini mcu shared definitions
 * bus widths, address map, control register offsets and error data
 */
package mcu_pkg;

  // bus geometry
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // sram banks, 32 KiB each
  localparam int unsigned       BANK_WORDS = 8192;
  localparam logic [ADDR_W-1:0] BANK_SIZE  = ADDR_W'(BANK_WORDS * BE_W);
  localparam logic [ADDR_W-1:0] RAM0_BASE  = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] RAM1_BASE  = 32'h0000_8000;

  // soc control block
  localparam logic [ADDR_W-1:0] SOC_CTRL_BASE = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] SOC_CTRL_SIZE = 32'h0000_0100;

  // register offsets inside the control block
  localparam logic [ADDR_W-1:0] EXIT_VALID_OFFSET = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] EXIT_VALUE_OFFSET = 32'h0000_0004;
  localparam logic [ADDR_W-1:0] SCRATCH_OFFSET    = 32'h0000_0008;

  // read data returned with an error response
  localparam logic [DATA_W-1:0] ERR_RDATA = 32'hBADC_AB1E;

  // slave select codes
  localparam logic [1:0] SEL_RAM0 = 2'd0;
  localparam logic [1:0] SEL_RAM1 = 2'd1;
  localparam logic [1:0] SEL_SOC  = 2'd2;
  localparam logic [1:0] SEL_ERR  = 2'd3;

endpackage

//--- hdl/obi_rr_arbiter.sv
/*
 * obi round-robin arbiter
 * shares one system bus between the instruction and data masters
 */
module obi_rr_arbiter (
  input  logic                       clk_i,
  input  logic                       rst_i,

  // instruction master, read only
  input  logic                       instr_req_i,
  input  logic [mcu_pkg::ADDR_W-1:0] instr_addr_i,
  output logic                       instr_gnt_o,
  output logic                       instr_rvalid_o,
  output logic [mcu_pkg::DATA_W-1:0] instr_rdata_o,
  output logic                       instr_err_o,

  // data master
  input  logic                       data_req_i,
  input  logic                       data_we_i,
  input  logic [  mcu_pkg::BE_W-1:0] data_be_i,
  input  logic [mcu_pkg::ADDR_W-1:0] data_addr_i,
  input  logic [mcu_pkg::DATA_W-1:0] data_wdata_i,
  output logic                       data_gnt_o,
  output logic                       data_rvalid_o,
  output logic [mcu_pkg::DATA_W-1:0] data_rdata_o,
  output logic                       data_err_o,

  // system bus
  output logic                       bus_req_o,
  output logic                       bus_we_o,
  output logic [  mcu_pkg::BE_W-1:0] bus_be_o,
  output logic [mcu_pkg::ADDR_W-1:0] bus_addr_o,
  output logic [mcu_pkg::DATA_W-1:0] bus_wdata_o,
  input  logic                       bus_rvalid_i,
  input  logic [mcu_pkg::DATA_W-1:0] bus_rdata_i,
  input  logic                       bus_err_i
);

  import mcu_pkg::*;

  // high when the data port wins a tie
  logic prio_data_q;
  // master that owns the response in flight
  logic owner_data_q;
  logic grant_data;
  logic grant_instr;

  assign grant_data  = data_req_i & (~instr_req_i | prio_data_q);
  assign grant_instr = instr_req_i & ~grant_data;

  assign instr_gnt_o = grant_instr;
  assign data_gnt_o  = grant_data;

  // instruction fetches go out as full-word reads
  assign bus_req_o   = grant_data | grant_instr;
  assign bus_we_o    = grant_data & data_we_i;
  assign bus_be_o    = grant_data ? data_be_i : {BE_W{1'b1}};
  assign bus_addr_o  = grant_data ? data_addr_i : instr_addr_i;
  assign bus_wdata_o = grant_data ? data_wdata_i : '0;

  // pointer moves away from the winner
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_data_q  <= 1'b1;
      owner_data_q <= 1'b0;
    end else if (bus_req_o) begin
      prio_data_q  <= grant_instr;
      owner_data_q <= grant_data;
    end
  end

  // steer the single response back
  assign data_rvalid_o  = bus_rvalid_i & owner_data_q;
  assign data_err_o     = bus_err_i & owner_data_q;
  assign data_rdata_o   = owner_data_q ? bus_rdata_i : '0;

  assign instr_rvalid_o = bus_rvalid_i & ~owner_data_q;
  assign instr_err_o    = bus_err_i & ~owner_data_q;
  assign instr_rdata_o  = owner_data_q ? '0 : bus_rdata_i;

endmodule

//--- hdl/obi_addr_demux.sv
/*
 * obi address demux
 * routes bus requests to one slave and muxes the responses back
 */
module obi_addr_demux (
  input  logic                       clk_i,
  input  logic                       rst_i,

  // from the arbiter
  input  logic                       bus_req_i,
  input  logic                       bus_we_i,
  input  logic [  mcu_pkg::BE_W-1:0] bus_be_i,
  input  logic [mcu_pkg::ADDR_W-1:0] bus_addr_i,
  input  logic [mcu_pkg::DATA_W-1:0] bus_wdata_i,
  output logic                       bus_rvalid_o,
  output logic [mcu_pkg::DATA_W-1:0] bus_rdata_o,
  output logic                       bus_err_o,

  // sram bank 0
  output logic                       ram0_req_o,
  output logic                       ram0_we_o,
  output logic [  mcu_pkg::BE_W-1:0] ram0_be_o,
  output logic [mcu_pkg::ADDR_W-1:0] ram0_addr_o,
  output logic [mcu_pkg::DATA_W-1:0] ram0_wdata_o,
  input  logic                       ram0_rvalid_i,
  input  logic [mcu_pkg::DATA_W-1:0] ram0_rdata_i,

  // sram bank 1
  output logic                       ram1_req_o,
  output logic                       ram1_we_o,
  output logic [  mcu_pkg::BE_W-1:0] ram1_be_o,
  output logic [mcu_pkg::ADDR_W-1:0] ram1_addr_o,
  output logic [mcu_pkg::DATA_W-1:0] ram1_wdata_o,
  input  logic                       ram1_rvalid_i,
  input  logic [mcu_pkg::DATA_W-1:0] ram1_rdata_i,

  // soc control block
  output logic                       soc_req_o,
  output logic                       soc_we_o,
  output logic [  mcu_pkg::BE_W-1:0] soc_be_o,
  output logic [mcu_pkg::ADDR_W-1:0] soc_addr_o,
  output logic [mcu_pkg::DATA_W-1:0] soc_wdata_o,
  input  logic                       soc_rvalid_i,
  input  logic [mcu_pkg::DATA_W-1:0] soc_rdata_i
);

  import mcu_pkg::*;

  logic [ADDR_W-1:0] ram0_off;
  logic [ADDR_W-1:0] ram1_off;
  logic [ADDR_W-1:0] soc_off;
  logic [1:0]        sel;
  logic [1:0]        sel_q;
  logic              err_rvalid_q;

  // offsets wrap when below the base, so one compare per region
  assign ram0_off = bus_addr_i - RAM0_BASE;
  assign ram1_off = bus_addr_i - RAM1_BASE;
  assign soc_off  = bus_addr_i - SOC_CTRL_BASE;

  always_comb begin
    sel = SEL_ERR;
    if (ram0_off < BANK_SIZE) begin
      sel = SEL_RAM0;
    end else if (ram1_off < BANK_SIZE) begin
      sel = SEL_RAM1;
    end else if (soc_off < SOC_CTRL_SIZE) begin
      sel = SEL_SOC;
    end
  end

  assign ram0_req_o   = bus_req_i & (sel == SEL_RAM0);
  assign ram0_we_o    = bus_we_i;
  assign ram0_be_o    = bus_be_i;
  assign ram0_addr_o  = ram0_off;
  assign ram0_wdata_o = bus_wdata_i;

  assign ram1_req_o   = bus_req_i & (sel == SEL_RAM1);
  assign ram1_we_o    = bus_we_i;
  assign ram1_be_o    = bus_be_i;
  assign ram1_addr_o  = ram1_off;
  assign ram1_wdata_o = bus_wdata_i;

  assign soc_req_o    = bus_req_i & (sel == SEL_SOC);
  assign soc_we_o     = bus_we_i;
  assign soc_be_o     = bus_be_i;
  assign soc_addr_o   = soc_off;
  assign soc_wdata_o  = bus_wdata_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q        <= SEL_ERR;
      err_rvalid_q <= 1'b0;
    end else begin
      err_rvalid_q <= bus_req_i & (sel == SEL_ERR);
      if (bus_req_i) begin
        sel_q <= sel;
      end
    end
  end

  // at most one of these is high in a cycle
  assign bus_rvalid_o = ram0_rvalid_i | ram1_rvalid_i | soc_rvalid_i | err_rvalid_q;
  assign bus_err_o    = err_rvalid_q;

  always_comb begin
    case (sel_q)
      SEL_RAM0: bus_rdata_o = ram0_rdata_i;
      SEL_RAM1: bus_rdata_o = ram1_rdata_i;
      SEL_SOC:  bus_rdata_o = soc_rdata_i;
      default:  bus_rdata_o = ERR_RDATA;
    endcase
  end

endmodule

//--- hdl/sram_bank.sv
/*
 * sram bank
 * single-port word memory, byte-enable writes, read data one cycle later
 */
module sram_bank #(
  parameter int unsigned NUM_WORDS = mcu_pkg::BANK_WORDS
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [  mcu_pkg::BE_W-1:0] be_i,
  input  logic [mcu_pkg::ADDR_W-1:0] addr_i,
  input  logic [mcu_pkg::DATA_W-1:0] wdata_i,
  output logic                       rvalid_o,
  output logic [mcu_pkg::DATA_W-1:0] rdata_o
);

  import mcu_pkg::*;

  localparam int unsigned IDX_W = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

  logic [DATA_W-1:0] mem_q [NUM_WORDS];
  logic [IDX_W-1:0]  word_idx;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;

  // byte offset in, word index out
  assign word_idx = addr_i[IDX_W+1:2];

  // a write also returns the old word
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= mem_q[word_idx];
      if (we_i) begin
        for (int b = 0; b < BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

//--- hdl/soc_ctrl.sv
/*
 * soc control block
 * exit value, sticky exit valid flag and a scratch word
 */
module soc_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [  mcu_pkg::BE_W-1:0] be_i,
  input  logic [mcu_pkg::ADDR_W-1:0] addr_i,
  input  logic [mcu_pkg::DATA_W-1:0] wdata_i,
  output logic                       rvalid_o,
  output logic [mcu_pkg::DATA_W-1:0] rdata_o,
  output logic                       exit_valid_o,
  output logic [mcu_pkg::DATA_W-1:0] exit_value_o
);

  import mcu_pkg::*;

  logic              exit_valid_q;
  logic [DATA_W-1:0] exit_value_q;
  logic [DATA_W-1:0] scratch_q;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] rdata_d;
  logic              wr_valid;
  logic              wr_value;
  logic              wr_scratch;

  assign wr_valid   = req_i & we_i & (addr_i == EXIT_VALID_OFFSET);
  assign wr_value   = req_i & we_i & (addr_i == EXIT_VALUE_OFFSET);
  assign wr_scratch = req_i & we_i & (addr_i == SCRATCH_OFFSET);

  always_comb begin
    case (addr_i)
      EXIT_VALID_OFFSET: rdata_d = {{(DATA_W-1){1'b0}}, exit_valid_q};
      EXIT_VALUE_OFFSET: rdata_d = exit_value_q;
      SCRATCH_OFFSET:    rdata_d = scratch_q;
      default:           rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
      rvalid_q     <= 1'b0;
      rdata_q      <= '0;
    end else begin
      rvalid_q <= req_i;
      if (req_i) begin
        rdata_q <= rdata_d;
      end
      // sticky until reset
      if (wr_valid && be_i[0] && wdata_i[0]) begin
        exit_valid_q <= 1'b1;
      end
      for (int b = 0; b < BE_W; b++) begin
        if (wr_value && be_i[b]) begin
          exit_value_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
        if (wr_scratch && be_i[b]) begin
          scratch_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign rvalid_o     = rvalid_q;
  assign rdata_o      = rdata_q;
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

//--- hdl/mini_mcu.sv
/*
 * mini mcu top level
 * two obi masters, arbiter, address demux, two sram banks and soc control
 */
module mini_mcu (
  input  logic                       clk_i,
  input  logic                       rst_i,

  input  logic                       instr_req_i,
  input  logic [mcu_pkg::ADDR_W-1:0] instr_addr_i,
  output logic                       instr_gnt_o,
  output logic                       instr_rvalid_o,
  output logic [mcu_pkg::DATA_W-1:0] instr_rdata_o,
  output logic                       instr_err_o,

  input  logic                       data_req_i,
  input  logic                       data_we_i,
  input  logic [  mcu_pkg::BE_W-1:0] data_be_i,
  input  logic [mcu_pkg::ADDR_W-1:0] data_addr_i,
  input  logic [mcu_pkg::DATA_W-1:0] data_wdata_i,
  output logic                       data_gnt_o,
  output logic                       data_rvalid_o,
  output logic [mcu_pkg::DATA_W-1:0] data_rdata_o,
  output logic                       data_err_o,

  output logic                       exit_valid_o,
  output logic [mcu_pkg::DATA_W-1:0] exit_value_o
);

  import mcu_pkg::*;

  // system bus between arbiter and demux
  logic              bus_req;
  logic              bus_we;
  logic [BE_W-1:0]   bus_be;
  logic [ADDR_W-1:0] bus_addr;
  logic [DATA_W-1:0] bus_wdata;
  logic              bus_rvalid;
  logic [DATA_W-1:0] bus_rdata;
  logic              bus_err;

  // slave ports
  logic              ram0_req, ram1_req, soc_req;
  logic              ram0_we, ram1_we, soc_we;
  logic [BE_W-1:0]   ram0_be, ram1_be, soc_be;
  logic [ADDR_W-1:0] ram0_addr, ram1_addr, soc_addr;
  logic [DATA_W-1:0] ram0_wdata, ram1_wdata, soc_wdata;
  logic              ram0_rvalid, ram1_rvalid, soc_rvalid;
  logic [DATA_W-1:0] ram0_rdata, ram1_rdata, soc_rdata;

  obi_rr_arbiter i_arbiter (
    .clk_i, .rst_i,
    .instr_req_i, .instr_addr_i, .instr_gnt_o,
    .instr_rvalid_o, .instr_rdata_o, .instr_err_o,
    .data_req_i, .data_we_i, .data_be_i, .data_addr_i, .data_wdata_i,
    .data_gnt_o, .data_rvalid_o, .data_rdata_o, .data_err_o,
    .bus_req_o    (bus_req),
    .bus_we_o     (bus_we),
    .bus_be_o     (bus_be),
    .bus_addr_o   (bus_addr),
    .bus_wdata_o  (bus_wdata),
    .bus_rvalid_i (bus_rvalid),
    .bus_rdata_i  (bus_rdata),
    .bus_err_i    (bus_err)
  );

  obi_addr_demux i_demux (
    .clk_i, .rst_i,
    .bus_req_i     (bus_req),
    .bus_we_i      (bus_we),
    .bus_be_i      (bus_be),
    .bus_addr_i    (bus_addr),
    .bus_wdata_i   (bus_wdata),
    .bus_rvalid_o  (bus_rvalid),
    .bus_rdata_o   (bus_rdata),
    .bus_err_o     (bus_err),
    .ram0_req_o    (ram0_req),
    .ram0_we_o     (ram0_we),
    .ram0_be_o     (ram0_be),
    .ram0_addr_o   (ram0_addr),
    .ram0_wdata_o  (ram0_wdata),
    .ram0_rvalid_i (ram0_rvalid),
    .ram0_rdata_i  (ram0_rdata),
    .ram1_req_o    (ram1_req),
    .ram1_we_o     (ram1_we),
    .ram1_be_o     (ram1_be),
    .ram1_addr_o   (ram1_addr),
    .ram1_wdata_o  (ram1_wdata),
    .ram1_rvalid_i (ram1_rvalid),
    .ram1_rdata_i  (ram1_rdata),
    .soc_req_o     (soc_req),
    .soc_we_o      (soc_we),
    .soc_be_o      (soc_be),
    .soc_addr_o    (soc_addr),
    .soc_wdata_o   (soc_wdata),
    .soc_rvalid_i  (soc_rvalid),
    .soc_rdata_i   (soc_rdata)
  );

  sram_bank #(.NUM_WORDS(BANK_WORDS)) i_ram0 (
    .clk_i, .rst_i,
    .req_i (ram0_req), .we_i (ram0_we), .be_i (ram0_be),
    .addr_i (ram0_addr), .wdata_i (ram0_wdata),
    .rvalid_o (ram0_rvalid), .rdata_o (ram0_rdata)
  );

  sram_bank #(.NUM_WORDS(BANK_WORDS)) i_ram1 (
    .clk_i, .rst_i,
    .req_i (ram1_req), .we_i (ram1_we), .be_i (ram1_be),
    .addr_i (ram1_addr), .wdata_i (ram1_wdata),
    .rvalid_o (ram1_rvalid), .rdata_o (ram1_rdata)
  );

  soc_ctrl i_soc_ctrl (
    .clk_i, .rst_i,
    .req_i (soc_req), .we_i (soc_we), .be_i (soc_be),
    .addr_i (soc_addr), .wdata_i (soc_wdata),
    .rvalid_o (soc_rvalid), .rdata_o (soc_rdata),
    .exit_valid_o, .exit_value_o
  );

endmodule

//--- dv/tb_mini_mcu.sv
/*
 * mini mcu testbench
 * directed bus tests from both masters against a reference memory model
 */
module tb_mini_mcu;
  timeunit 1ns;
  timeprecision 1ps;

  import mcu_pkg::*;

  localparam int unsigned SEED = 32'he47d_a1ca;
  // the tests need under 200 cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int NUM_TEST_WORDS = 8;
  // just past ram1 and aliasing ram0 word 0 on the low address bits
  localparam logic [ADDR_W-1:0] UNMAPPED_ADDR = 32'h0001_0000;

  logic              clk_i;
  logic              rst_i;
  logic              instr_req_i;
  logic [ADDR_W-1:0] instr_addr_i;
  logic              instr_gnt_o;
  logic              instr_rvalid_o;
  logic [DATA_W-1:0] instr_rdata_o;
  logic              instr_err_o;
  logic              data_req_i;
  logic              data_we_i;
  logic [BE_W-1:0]   data_be_i;
  logic [ADDR_W-1:0] data_addr_i;
  logic [DATA_W-1:0] data_wdata_i;
  logic              data_gnt_o;
  logic              data_rvalid_o;
  logic [DATA_W-1:0] data_rdata_o;
  logic              data_err_o;
  logic              exit_valid_o;
  logic [DATA_W-1:0] exit_value_o;

  // word address to expected contents
  logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];
  // high when the last grant went to the instruction port
  logic              last_instr;
  int                errors = 0;
  int                cycles = 0;

  mini_mcu i_dut (
    .clk_i, .rst_i,
    .instr_req_i, .instr_addr_i, .instr_gnt_o,
    .instr_rvalid_o, .instr_rdata_o, .instr_err_o,
    .data_req_i, .data_we_i, .data_be_i, .data_addr_i, .data_wdata_i,
    .data_gnt_o, .data_rvalid_o, .data_rdata_o, .data_err_o,
    .exit_valid_o, .exit_value_o
  );

  initial begin
    clk_i = 1'b0;
  end

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, got %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    #1;
    rst_i = 1'b1;
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    last_instr = 1'b1;
  endtask

  task automatic data_access(input logic we, input logic [BE_W-1:0] be,
                             input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             output logic [DATA_W-1:0] rdata, output logic err);
    @(posedge clk_i);
    #1;
    data_req_i   = 1'b1;
    data_we_i    = we;
    data_be_i    = be;
    data_addr_i  = addr;
    data_wdata_i = wdata;
    @(negedge clk_i);
    while (data_gnt_o !== 1'b1) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    data_req_i = 1'b0;
    last_instr = 1'b0;
    @(negedge clk_i);
    check_bit(data_rvalid_o, 1'b1, "data rvalid one cycle after gnt");
    rdata = data_rdata_o;
    err   = data_err_o;
  endtask

  task automatic instr_read(input logic [ADDR_W-1:0] addr,
                            output logic [DATA_W-1:0] rdata, output logic err);
    @(posedge clk_i);
    #1;
    instr_req_i  = 1'b1;
    instr_addr_i = addr;
    @(negedge clk_i);
    while (instr_gnt_o !== 1'b1) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    instr_req_i = 1'b0;
    last_instr  = 1'b1;
    @(negedge clk_i);
    check_bit(instr_rvalid_o, 1'b1, "instr rvalid one cycle after gnt");
    rdata = instr_rdata_o;
    err   = instr_err_o;
  endtask

  task automatic ram_write(input logic [ADDR_W-1:0] addr, input logic [BE_W-1:0] be,
                           input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic [DATA_W-1:0] old_word;
    old_word = ref_mem.exists(addr >> 2) ? ref_mem[addr >> 2] : 'x;
    data_access(1'b1, be, addr, wdata, rdata, err);
    check_bit(err, 1'b0, "ram write err");
    // a write answers with the previous word
    if (ref_mem.exists(addr >> 2)) begin
      check_word(rdata, old_word, $sformatf("old word on write at %h", addr));
    end
    ref_mem[addr >> 2] = merge_bytes(old_word, wdata, be);
  endtask

  task automatic check_ram(input logic [ADDR_W-1:0] addr, input logic use_instr);
    logic [DATA_W-1:0] rdata;
    logic              err;
    if (use_instr) begin
      instr_read(addr, rdata, err);
    end else begin
      data_access(1'b0, '1, addr, '0, rdata, err);
    end
    check_word(rdata, ref_mem[addr >> 2], $sformatf("read data at %h", addr));
    check_bit(err, 1'b0, "ram read err");
  endtask

  // one request per cycle from one or both masters
  task automatic read_stream(input int n, input logic with_instr);
    logic [ADDR_W-1:0] d_addr;
    logic [ADDR_W-1:0] i_addr;
    logic [ADDR_W-1:0] pend_addr;
    logic              pend;
    logic              pend_data;
    logic              exp_data;
    d_addr = RAM0_BASE;
    i_addr = RAM1_BASE;
    pend   = 1'b0;
    @(posedge clk_i);
    #1;
    data_req_i   = 1'b1;
    data_we_i    = 1'b0;
    data_be_i    = '1;
    data_addr_i  = d_addr;
    instr_req_i  = with_instr;
    instr_addr_i = i_addr;
    for (int k = 0; k <= n; k++) begin
      @(negedge clk_i);
      if (pend && pend_data) begin
        check_bit(data_rvalid_o, 1'b1, "stream data rvalid");
        check_bit(instr_rvalid_o, 1'b0, "stream instr rvalid idle");
        check_word(data_rdata_o, ref_mem[pend_addr >> 2], "stream data rdata");
      end else if (pend) begin
        check_bit(instr_rvalid_o, 1'b1, "stream instr rvalid");
        check_bit(data_rvalid_o, 1'b0, "stream data rvalid idle");
        check_word(instr_rdata_o, ref_mem[pend_addr >> 2], "stream instr rdata");
      end
      pend = 1'b0;
      if (k < n) begin
        // the master not granted last time wins a tie
        exp_data = !with_instr || last_instr;
        check_bit(data_gnt_o, exp_data, "stream data gnt");
        check_bit(instr_gnt_o, with_instr && !exp_data, "stream instr gnt");
        pend       = 1'b1;
        pend_data  = exp_data;
        pend_addr  = exp_data ? d_addr : i_addr;
        last_instr = !exp_data;
      end
      @(posedge clk_i);
      #1;
      if (pend && pend_data) begin
        d_addr      = d_addr + 4;
        data_addr_i = d_addr;
      end else if (pend) begin
        i_addr       = i_addr + 4;
        instr_addr_i = i_addr;
      end
      if (k == n - 1) begin
        data_req_i  = 1'b0;
        instr_req_i = 1'b0;
      end
    end
  endtask

  task automatic test_reset_state();
    check_bit(exit_valid_o, 1'b0, "exit valid after reset");
    check_word(exit_value_o, '0, "exit value after reset");
  endtask

  task automatic test_ram0_byte_writes();
    for (int k = 0; k < NUM_TEST_WORDS; k++) begin
      ram_write(RAM0_BASE + 4 * k, '1, $urandom());
    end
    for (int k = 0; k < NUM_TEST_WORDS; k++) begin
      ram_write(RAM0_BASE + 4 * k, BE_W'(k + 1), $urandom());
    end
    for (int k = 0; k < NUM_TEST_WORDS; k++) begin
      check_ram(RAM0_BASE + 4 * k, k[0]);
    end
  endtask

  task automatic test_bank_separation();
    for (int k = 0; k < NUM_TEST_WORDS; k++) begin
      ram_write(RAM1_BASE + 4 * k, '1, ~ref_mem[(RAM0_BASE + 4 * k) >> 2]);
    end
    for (int k = 0; k < NUM_TEST_WORDS; k++) begin
      check_ram(RAM0_BASE + 4 * k, 1'b0);
      check_ram(RAM1_BASE + 4 * k, 1'b1);
    end
  endtask

  task automatic test_soc_and_errors();
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic [DATA_W-1:0] value;
    data_access(1'b0, '1, 32'h1000_0000, '0, rdata, err);
    check_bit(err, 1'b1, "unmapped data read err");
    check_word(rdata, ERR_RDATA, "unmapped data read data");
    instr_read(32'h3000_0000, rdata, err);
    check_bit(err, 1'b1, "unmapped instr read err");
    check_word(rdata, ERR_RDATA, "unmapped instr read data");
    data_access(1'b1, '1, UNMAPPED_ADDR, 32'hdead_beef, rdata, err);
    check_bit(err, 1'b1, "unmapped write err");
    check_ram(RAM0_BASE, 1'b0);
    check_ram(RAM1_BASE, 1'b0);
    value = $urandom();
    data_access(1'b1, '1, SOC_CTRL_BASE + EXIT_VALUE_OFFSET, value, rdata, err);
    check_bit(err, 1'b0, "exit value write err");
    check_word(exit_value_o, value, "exit value output");
    check_bit(exit_valid_o, 1'b0, "exit valid before flag write");
    data_access(1'b1, '1, SOC_CTRL_BASE + EXIT_VALID_OFFSET, 32'h1, rdata, err);
    check_bit(exit_valid_o, 1'b1, "exit valid after flag write");
    data_access(1'b1, '1, SOC_CTRL_BASE + EXIT_VALID_OFFSET, 32'h0, rdata, err);
    check_bit(exit_valid_o, 1'b1, "exit valid sticky");
    data_access(1'b0, '1, SOC_CTRL_BASE + EXIT_VALUE_OFFSET, '0, rdata, err);
    check_word(rdata, value, "exit value readback");
    value = $urandom();
    data_access(1'b1, '1, SOC_CTRL_BASE + SCRATCH_OFFSET, value, rdata, err);
    data_access(1'b0, '1, SOC_CTRL_BASE + SCRATCH_OFFSET, '0, rdata, err);
    check_word(rdata, value, "scratch readback");
    check_bit(err, 1'b0, "scratch read err");
  endtask

  initial begin
    rst_i        = 1'b1;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    data_req_i   = 1'b0;
    data_we_i    = 1'b0;
    data_be_i    = '0;
    data_addr_i  = '0;
    data_wdata_i = '0;
    last_instr   = 1'b1;
    void'($urandom(SEED));
    apply_reset();
    test_reset_state();
    test_ram0_byte_writes();
    test_bank_separation();
    // second reset restarts the pointer on the data port while memories keep their contents
    apply_reset();
    read_stream(NUM_TEST_WORDS, 1'b1);
    read_stream(NUM_TEST_WORDS, 1'b0);
    test_soc_and_errors();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- build.f
hdl/mcu_pkg.sv
hdl/obi_rr_arbiter.sv
hdl/obi_addr_demux.sv
hdl/sram_bank.sv
hdl/soc_ctrl.sv
hdl/mini_mcu.sv
dv/tb_mini_mcu.sv

//--- Bender.yml
package:
  name: mini_mcu

sources:
  - hdl/mcu_pkg.sv
  - hdl/obi_rr_arbiter.sv
  - hdl/obi_addr_demux.sv
  - hdl/sram_bank.sv
  - hdl/soc_ctrl.sv
  - hdl/mini_mcu.sv
  - target: simulation
    files:
      - dv/tb_mini_mcu.sv
